/* design/fm_regmap_pkg.sv */
// Register map of part 0 only; operator groups 3 to 9 are decoded alike in both parts
package fm_regmap_pkg;

    // Global register numbers
    localparam logic [7:0] reg_testym  = 8'h21; // Test bits, timer speed-up
    localparam logic [7:0] reg_lfo     = 8'h22;
    localparam logic [7:0] reg_clka1   = 8'h24; // Timer A, upper 8 bits
    localparam logic [7:0] reg_clka2   = 8'h25; // Timer A, lower 2 bits
    localparam logic [7:0] reg_clkb    = 8'h26;
    localparam logic [7:0] reg_timer   = 8'h27; // Mode, reset, enable, load
    localparam logic [7:0] reg_pcm     = 8'h2A;
    localparam logic [7:0] reg_pcm_en  = 8'h2B;
    localparam logic [7:0] reg_dactest = 8'h2C;

    // Prescaler selection, acts on the address write alone
    localparam logic [7:0] reg_clk_n6  = 8'h2D;
    localparam logic [7:0] reg_clk_n3  = 8'h2E;
    localparam logic [7:0] reg_clk_n2  = 8'h2F;

    // Operator register groups, 3x (DT/MUL) up to 9x (SSG-EG)
    localparam logic [3:0] op_group_first = 4'd3;
    localparam logic [3:0] op_group_last  = 4'd9;

    // Latched register number
    // Global registers read it whole, operator registers read it by field
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] group; // Upper nibble
            logic [1:0] slot;  // Operator, 0=S1 1=S3 2=S2 3=S4
            logic [1:0] ch;    // Channel within the part, 3 is unused
        } f;
    } reg_addr_u;

    // One-hot operator update strobe, bit n is group n+3
    typedef logic [6:0] op_up_t;

endpackage

/* design/fm_timing_pkg.sv */
// Prescaler covers the FM clock enable only; ratios must stay below 8 to fit the counter
package fm_timing_pkg;

    // Prescaler setting, built bit by bit from writes to 2D and 2E
    typedef logic [1:0] div_t;

    // Divide by 6 out of reset
    localparam div_t div_reset = 2'd2;

    // cen-high cycles per clk_en pulse
    localparam logic [2:0] ratio_6 = 3'd6; // Code 2
    localparam logic [2:0] ratio_3 = 3'd3; // Codes 1 and 3
    localparam logic [2:0] ratio_2 = 3'd2; // Code 0

endpackage

/* design/fm_reg_decoder.sv */
// Writes are taken as they come, busy is not checked; PCM decode only exists with use_pcm set
module fm_reg_decoder #(
    parameter bit use_pcm = 1'b1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            din,
    input  logic                  write,
    input  logic [1:0]            addr,
    input  logic                  clk_en,
    // Test and LFO
    output logic                  eg_stop,
    output logic                  pg_stop,
    output logic                  fast_timers,
    output logic [2:0]            lfo_freq,
    output logic                  lfo_en,
    // Timers
    output logic [9:0]            value_a,
    output logic [7:0]            value_b,
    output logic                  load_a,
    output logic                  load_b,
    output logic                  enable_irq_a,
    output logic                  enable_irq_b,
    output logic                  clr_flag_a,
    output logic                  clr_flag_b,
    output logic                  csm,
    output logic                  effect,
    // PCM
    output logic [8:0]            pcm,
    output logic                  pcm_en,
    output logic                  pcm_wr,
    // Operator updates
    output fm_regmap_pkg::op_up_t op_up,
    output logic [2:0]            up_ch,
    output logic [1:0]            up_op,
    output logic [7:0]            reg_data
);

    fm_regmap_pkg::reg_addr_u sel; // Register picked by the last address write
    logic                     part;
    logic                     addr_wr;
    logic                     data_wr;
    logic                     op_hit;

    assign addr_wr = write && !addr[0];
    assign data_wr = write && addr[0];

    // Operator group in range and a real channel
    assign op_hit = sel.f.group >= fm_regmap_pkg::op_group_first &&
                    sel.f.group <= fm_regmap_pkg::op_group_last &&
                    sel.f.ch != 2'd3;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel          <= '0;
            part         <= 1'b0;
            eg_stop      <= 1'b0;
            pg_stop      <= 1'b0;
            fast_timers  <= 1'b0;
            lfo_freq     <= 3'd0;
            lfo_en       <= 1'b0;
            value_a      <= 10'd0;
            value_b      <= 8'd0;
            load_a       <= 1'b0;
            load_b       <= 1'b0;
            enable_irq_a <= 1'b0;
            enable_irq_b <= 1'b0;
            clr_flag_a   <= 1'b0;
            clr_flag_b   <= 1'b0;
            csm          <= 1'b0;
            effect       <= 1'b0;
            pcm          <= 9'd0;
            pcm_en       <= 1'b0;
            pcm_wr       <= 1'b0;
            op_up        <= '0;
        end else if (addr_wr) begin
            sel.raw <= din;
            part    <= addr[1];
        end else if (data_wr) begin
            if (!part) begin
                case (sel.raw)
                    fm_regmap_pkg::reg_testym: begin
                        eg_stop     <= din[5];
                        pg_stop     <= din[3];
                        fast_timers <= din[2];
                    end
                    fm_regmap_pkg::reg_lfo:   {lfo_en, lfo_freq} <= din[3:0];
                    fm_regmap_pkg::reg_clka1: value_a[9:2] <= din;
                    fm_regmap_pkg::reg_clka2: value_a[1:0] <= din[1:0];
                    fm_regmap_pkg::reg_clkb:  value_b <= din;
                    fm_regmap_pkg::reg_timer: begin
                        effect <= |din[7:6];        // Any non-normal CH3 mode
                        csm    <= din[7:6] == 2'b10;
                        {clr_flag_b, clr_flag_a, enable_irq_b, enable_irq_a, load_b, load_a}
                            <= din[5:0];
                    end
                    default: ;
                endcase
                if (use_pcm) begin
                    case (sel.raw)
                        fm_regmap_pkg::reg_pcm:     pcm <= {~din[7], din[6:0], 1'b1};
                        fm_regmap_pkg::reg_dactest: pcm[0] <= din[3]; // Extra DAC bit
                        fm_regmap_pkg::reg_pcm_en:  pcm_en <= din[7];
                        default: ;
                    endcase
                end
            end
            pcm_wr <= use_pcm && !part && sel.raw == fm_regmap_pkg::reg_pcm;

            // Group 3 lands on bit 0
            if (op_hit)
                op_up <= fm_regmap_pkg::op_up_t'(1) << (sel.f.group - fm_regmap_pkg::op_group_first);
            else
                op_up <= '0;
        end else if (clk_en) begin
            // One-shot strobes end on the next idle tick
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            pcm_wr     <= 1'b0;
        end
    end

    // Target of the last data write, held for the operator bank
    always_ff @(posedge clk) begin
        if (data_wr) begin
            reg_data <= din;
            up_ch    <= {part, sel.f.ch};
            up_op    <= sel.f.slot;
        end
    end

    a_op_up_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(op_up));

    // The DAC strobe never outlives an idle clock enable
    a_pcm_wr_clear: assert property (
        @(posedge clk) disable iff (rst) (clk_en && !write) |=> !pcm_wr
    );

endmodule

/* design/fm_busy_clock.sv */
// Prescaler reacts to address writes in either part; busy_len must be at least 1
module fm_busy_clock #(
    parameter int busy_len = 32
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [7:0] din,
    input  logic       write,
    input  logic [1:0] addr,
    output logic       clk_en,
    output logic       busy
);

    localparam int cnt_w = (busy_len > 1) ? $clog2(busy_len) : 1;

    fm_timing_pkg::div_t div_setting;
    logic [2:0]          ratio;
    logic [2:0]          cen_cnt;
    logic                old_write;
    logic                data_rise;
    logic [cnt_w-1:0]    busy_cnt;

    always_comb begin
        case (div_setting)
            2'd2:       ratio = fm_timing_pkg::ratio_6;
            2'd1, 2'd3: ratio = fm_timing_pkg::ratio_3;
            default:    ratio = fm_timing_pkg::ratio_2;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_setting <= fm_timing_pkg::div_reset;
        end else if (write && !addr[0]) begin
            case (din)
                fm_regmap_pkg::reg_clk_n6: div_setting[1] <= 1'b1;
                fm_regmap_pkg::reg_clk_n3: div_setting[0] <= 1'b1;
                fm_regmap_pkg::reg_clk_n2: div_setting    <= 2'd0;
                default: ;
            endcase
        end
    end

    // cen counter, >= catches a ratio that shrank mid-count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= 3'd0;
            clk_en  <= 1'b0;
        end else begin
            clk_en <= cen && cen_cnt >= ratio - 3'd1;
            if (cen)
                cen_cnt <= (cen_cnt >= ratio - 3'd1) ? 3'd0 : cen_cnt + 3'd1;
        end
    end

    assign data_rise = write && !old_write && addr[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            old_write <= 1'b0;
            busy      <= 1'b0;
            busy_cnt  <= '0;
        end else begin
            old_write <= write;
            if (data_rise) begin
                busy     <= 1'b1; // Restart on every new data write
                busy_cnt <= '0;
            end else if (clk_en && busy) begin
                if (busy_cnt == cnt_w'(busy_len - 1))
                    busy <= 1'b0;
                busy_cnt <= busy_cnt + 1'b1;
            end
        end
    end

    a_clk_en_single: assert property (@(posedge clk) disable iff (rst) clk_en |=> !clk_en);

    // Busy only ends on an FM tick
    a_busy_fall: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> $past(clk_en));

endmodule

/* design/fm_status.sv */
// Timer flags come from outside and are taken as synchronous to clk
module fm_status (
    input  logic       clk,
    input  logic       rst,
    input  logic       busy,
    input  logic       flag_a,
    input  logic       flag_b,
    input  logic       enable_irq_a,
    input  logic       enable_irq_b,
    output logic [7:0] status,
    output logic       irq_n
);

    logic irq_req;

    assign irq_req = (flag_a && enable_irq_a) || (flag_b && enable_irq_b);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status <= 8'd0;
            irq_n  <= 1'b1;
        end else begin
            status <= {busy, 5'd0, flag_b, flag_a}; // Read-back byte
            irq_n  <= !irq_req;                     // Active low
        end
    end

    // Interrupt only with a flag shown in status whose enable was set
    a_irq_cause: assert property (
        @(posedge clk) disable iff (rst)
        !irq_n |-> (status[0] && $past(enable_irq_a)) || (status[1] && $past(enable_irq_b))
    );

endmodule

/* design/fm_mmr_top.sv */
// Write side only; the operator register bank hangs off op_up, up_ch, up_op and reg_data
module fm_mmr_top #(
    parameter int busy_len = 32,
    parameter bit use_pcm  = 1'b1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  logic [7:0]            din,
    input  logic                  write,
    input  logic [1:0]            addr,
    input  logic                  flag_a,
    input  logic                  flag_b,
    output logic                  clk_en,
    output logic                  busy,
    output logic [7:0]            status,
    output logic                  irq_n,
    output logic                  eg_stop,
    output logic                  pg_stop,
    output logic                  fast_timers,
    output logic [2:0]            lfo_freq,
    output logic                  lfo_en,
    output logic [9:0]            value_a,
    output logic [7:0]            value_b,
    output logic                  load_a,
    output logic                  load_b,
    output logic                  enable_irq_a,
    output logic                  enable_irq_b,
    output logic                  clr_flag_a,
    output logic                  clr_flag_b,
    output logic                  csm,
    output logic                  effect,
    output logic [8:0]            pcm,
    output logic                  pcm_en,
    output logic                  pcm_wr,
    output fm_regmap_pkg::op_up_t op_up,
    output logic [2:0]            up_ch,
    output logic [1:0]            up_op,
    output logic [7:0]            reg_data
);

    fm_reg_decoder #(
        .use_pcm(use_pcm)
    ) u_decoder (
        .clk         (clk),
        .rst         (rst),
        .din         (din),
        .write       (write),
        .addr        (addr),
        .clk_en      (clk_en),
        .eg_stop     (eg_stop),
        .pg_stop     (pg_stop),
        .fast_timers (fast_timers),
        .lfo_freq    (lfo_freq),
        .lfo_en      (lfo_en),
        .value_a     (value_a),
        .value_b     (value_b),
        .load_a      (load_a),
        .load_b      (load_b),
        .enable_irq_a(enable_irq_a),
        .enable_irq_b(enable_irq_b),
        .clr_flag_a  (clr_flag_a),
        .clr_flag_b  (clr_flag_b),
        .csm         (csm),
        .effect      (effect),
        .pcm         (pcm),
        .pcm_en      (pcm_en),
        .pcm_wr      (pcm_wr),
        .op_up       (op_up),
        .up_ch       (up_ch),
        .up_op       (up_op),
        .reg_data    (reg_data)
    );

    fm_busy_clock #(
        .busy_len(busy_len)
    ) u_busy_clock (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .din   (din),
        .write (write),
        .addr  (addr),
        .clk_en(clk_en),
        .busy  (busy)
    );

    fm_status u_status (
        .clk         (clk),
        .rst         (rst),
        .busy        (busy),
        .flag_a      (flag_a),
        .flag_b      (flag_b),
        .enable_irq_a(enable_irq_a),
        .enable_irq_b(enable_irq_b),
        .status      (status),
        .irq_n       (irq_n)
    );

endmodule

/* verif/fm_mmr_vectors.svh */
// Included inside the testbench module; rows run in order and expect the state left by earlier rows
`ifndef FM_MMR_VECTORS_SVH
`define FM_MMR_VECTORS_SVH

// Columns: part, register, data, expected register word, op_up, up_ch, up_op
// up_ch and up_op are only compared when op_up is nonzero
typedef struct packed {
    logic       part;
    logic [7:0] regnum;
    logic [7:0] data;
    logic [9:0] exp_val;
    logic [6:0] exp_op;
    logic [2:0] exp_ch;
    logic [1:0] exp_slot;
} vec_t;

localparam int n_vec = 29;

localparam vec_t vectors [n_vec] = '{
    '{1'b0, 8'h21, 8'h2C, 10'h007, 7'h00, 3'd0, 2'd0}, // All three test bits
    '{1'b0, 8'h21, 8'h24, 10'h005, 7'h00, 3'd0, 2'd0},
    '{1'b1, 8'h21, 8'h08, 10'h005, 7'h00, 3'd0, 2'd0}, // Part 1 leaves it alone
    '{1'b0, 8'h22, 8'h0D, 10'h00D, 7'h00, 3'd0, 2'd0},
    '{1'b0, 8'h24, 8'hA5, 10'h294, 7'h00, 3'd0, 2'd0}, // Timer A upper bits
    '{1'b0, 8'h25, 8'hFE, 10'h296, 7'h00, 3'd0, 2'd0},
    '{1'b1, 8'h24, 8'h11, 10'h296, 7'h00, 3'd0, 2'd0},
    '{1'b0, 8'h26, 8'h3C, 10'h03C, 7'h00, 3'd0, 2'd0},
    // Register 27 word is {csm, effect, din[5:0]}
    '{1'b0, 8'h27, 8'h15, 10'h015, 7'h00, 3'd0, 2'd0},
    '{1'b0, 8'h27, 8'hAA, 10'h0EA, 7'h00, 3'd0, 2'd0}, // CSM mode
    '{1'b0, 8'h27, 8'h4F, 10'h04F, 7'h00, 3'd0, 2'd0},
    '{1'b0, 8'h27, 8'hCC, 10'h04C, 7'h00, 3'd0, 2'd0}, // Mode 3 is effect only
    '{1'b1, 8'h27, 8'hFF, 10'h04C, 7'h00, 3'd0, 2'd0},
    '{1'b0, 8'h2B, 8'h80, 10'h001, 7'h00, 3'd0, 2'd0},
    '{1'b0, 8'h2A, 8'h35, 10'h16B, 7'h00, 3'd0, 2'd0}, // Sign bit flipped, low bit set
    '{1'b0, 8'h2A, 8'hC2, 10'h085, 7'h00, 3'd0, 2'd0},
    '{1'b0, 8'h2C, 8'h00, 10'h084, 7'h00, 3'd0, 2'd0},
    '{1'b0, 8'h2C, 8'h08, 10'h085, 7'h00, 3'd0, 2'd0},
    '{1'b1, 8'h2A, 8'h00, 10'h085, 7'h00, 3'd0, 2'd0},
    // Operator groups, word is reg_data
    '{1'b0, 8'h30, 8'h71, 10'h071, 7'h01, 3'd0, 2'd0},
    '{1'b0, 8'h45, 8'h1F, 10'h01F, 7'h02, 3'd1, 2'd1},
    '{1'b1, 8'h5A, 8'hC3, 10'h0C3, 7'h04, 3'd6, 2'd2},
    '{1'b1, 8'h6E, 8'h0F, 10'h00F, 7'h08, 3'd6, 2'd3},
    '{1'b0, 8'h71, 8'h5A, 10'h05A, 7'h10, 3'd1, 2'd0},
    '{1'b1, 8'h84, 8'h99, 10'h099, 7'h20, 3'd4, 2'd1},
    '{1'b0, 8'h9B, 8'h42, 10'h042, 7'h00, 3'd0, 2'd0}, // Channel 3 does not exist
    '{1'b1, 8'h96, 8'hE7, 10'h0E7, 7'h40, 3'd6, 2'd1},
    '{1'b0, 8'hA0, 8'h11, 10'h011, 7'h00, 3'd0, 2'd0},
    '{1'b0, 8'h22, 8'h03, 10'h003, 7'h00, 3'd0, 2'd0}
};

`endif

/* verif/fm_mmr_tb.sv */
// Table rows assume the divide-by-6 prescaler; busy_len here has to match the DUT parameter
module fm_mmr_tb;

    localparam int busy_len = 32;

    `include "fm_mmr_vectors.svh"

    logic                  clk;
    logic                  rst;
    logic                  cen;
    logic [7:0]            din;
    logic                  write;
    logic [1:0]            addr;
    logic                  flag_a;
    logic                  flag_b;
    logic                  clk_en, busy, irq_n;
    logic [7:0]            status;
    logic                  eg_stop, pg_stop, fast_timers, lfo_en;
    logic [2:0]            lfo_freq;
    logic [9:0]            value_a;
    logic [7:0]            value_b;
    logic                  load_a, load_b, enable_irq_a, enable_irq_b;
    logic                  clr_flag_a, clr_flag_b, csm, effect;
    logic [8:0]            pcm;
    logic                  pcm_en, pcm_wr;
    fm_regmap_pkg::op_up_t op_up;
    logic [2:0]            up_ch;
    logic [1:0]            up_op;
    logic [7:0]            reg_data;
    logic [31:0]           lcg_state;

    fm_mmr_top #(.busy_len(busy_len), .use_pcm(1'b1)) u_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Outputs that one register sets, packed into one word
    function automatic logic [9:0] reg_word(input logic [7:0] r);
        case (r)
            fm_regmap_pkg::reg_testym: return {7'd0, eg_stop, pg_stop, fast_timers};
            fm_regmap_pkg::reg_lfo:    return {6'd0, lfo_en, lfo_freq};
            fm_regmap_pkg::reg_clka1,
            fm_regmap_pkg::reg_clka2:  return value_a;
            fm_regmap_pkg::reg_clkb:   return {2'd0, value_b};
            fm_regmap_pkg::reg_timer:
                return {2'd0, csm, effect, clr_flag_b, clr_flag_a,
                        enable_irq_b, enable_irq_a, load_b, load_a};
            fm_regmap_pkg::reg_pcm,
            fm_regmap_pkg::reg_dactest: return {1'b0, pcm};
            fm_regmap_pkg::reg_pcm_en:  return {9'd0, pcm_en};
            default:                    return {2'd0, reg_data};
        endcase
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_byte(input string name, input logic [9:0] got, input logic [9:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_op_up(input fm_regmap_pkg::op_up_t got, input fm_regmap_pkg::op_up_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAIL t=%0t op_up got %b expected %b", $time, got, exp));
    endtask

    task automatic check_status(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("FAIL t=%0t status got %b expected %b", $time, got, exp));
    endtask

    // Called on a falling edge, returns on a falling edge one idle cycle later
    task automatic addr_write(input logic part, input logic [7:0] r);
        write = 1'b1;
        addr  = {part, 1'b0};
        din   = r;
        @(negedge clk);
        write = 1'b0;
        @(negedge clk);
    endtask

    // Returns on the first falling edge after the write took effect
    task automatic data_write(input logic part, input logic [7:0] d);
        write = 1'b1;
        addr  = {part, 1'b1};
        din   = d;
        @(negedge clk);
        write = 1'b0;
    endtask

    task automatic wait_clk_en();
        int guard;
        guard = 0;
        while (!clk_en) begin
            @(negedge clk);
            guard++;
            if (guard > 20)
                stop_with_failure("clk_en did not pulse while waiting for it");
        end
    endtask

    task automatic wait_busy_low();
        int guard;
        guard = 0;
        while (busy) begin
            @(negedge clk);
            guard++;
            if (guard > busy_len * 8 + 16)
                stop_with_failure("busy never went low");
        end
    endtask

    // busy must stay high across n clk_en ticks seen from here on
    task automatic count_busy(input int n);
        int ticks;
        int guard;
        ticks = 0;
        guard = 0;
        while (ticks < n) begin
            check_bit("busy", busy, 1'b1);
            if (clk_en)
                ticks++;
            @(negedge clk);
            guard++;
            if (guard > n * 8 + 16)
                stop_with_failure("too few clk_en ticks while counting busy");
        end
    endtask

    task automatic count_window(input int exp_pulses);
        int          cen_high;
        int          pulses;
        logic [31:0] r;
        cen_high = 0;
        pulses   = 0;
        while (cen_high < 60) begin
            r   = next_random();
            cen = r[16];
            if (r[16])
                cen_high++;
            @(negedge clk);
            if (clk_en)
                pulses++;
        end
        cen = 1'b1;
        if (pulses < exp_pulses - 1 || pulses > exp_pulses + 1)
            stop_with_failure($sformatf("FAIL t=%0t clk_en count got %0d expected %0d",
                                        $time, pulses, exp_pulses));
    endtask

    initial begin
        repeat (n_vec * 400 + 2000) @(posedge clk);
        stop_with_failure("Watchdog timeout, the tests did not finish in time");
    end

    initial begin
        vec_t        v;
        logic [31:0] r;
        clk       = 1'b0;
        rst       = 1'b1;
        cen       = 1'b1;
        din       = 8'd0;
        write     = 1'b0;
        addr      = 2'd0;
        flag_a    = 1'b0;
        flag_b    = 1'b0;
        lcg_state = 32'h4ef4_446b;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_bit("busy", busy, 1'b0);
        check_bit("irq_n", irq_n, 1'b1);
        check_op_up(op_up, '0);

        // Register table
        for (int i = 0; i < n_vec; i++) begin
            v = vectors[i];
            addr_write(v.part, v.regnum);
            data_write(v.part, v.data);
            check_byte($sformatf("word_%02h", v.regnum), reg_word(v.regnum), v.exp_val);
            check_op_up(op_up, v.exp_op);
            if (v.exp_op != '0) begin
                check_byte("up_ch", {7'd0, up_ch}, {7'd0, v.exp_ch});
                check_byte("up_op", {8'd0, up_op}, {8'd0, v.exp_slot});
            end
            check_bit("pcm_wr", pcm_wr, !v.part && v.regnum == fm_regmap_pkg::reg_pcm);
            wait_clk_en();
            @(negedge clk);
            check_bit("clr_flag_a", clr_flag_a, 1'b0); // Strobes gone after an idle tick
            check_bit("clr_flag_b", clr_flag_b, 1'b0);
            check_bit("pcm_wr", pcm_wr, 1'b0);
        end

        // Busy, with a restart part way through
        wait_busy_low();
        addr_write(1'b0, fm_regmap_pkg::reg_lfo);
        check_bit("busy", busy, 1'b0);
        data_write(1'b0, 8'h03);
        count_busy(10);
        data_write(1'b0, 8'h03);
        count_busy(busy_len);
        check_bit("busy", busy, 1'b0);

        // Prescaler, code 3 also divides by 3
        addr_write(1'b0, fm_regmap_pkg::reg_clk_n2);
        count_window(30);
        addr_write(1'b0, fm_regmap_pkg::reg_clk_n3);
        count_window(20);
        addr_write(1'b1, fm_regmap_pkg::reg_clk_n6);
        count_window(20);
        addr_write(1'b0, fm_regmap_pkg::reg_clk_n2);
        addr_write(1'b0, fm_regmap_pkg::reg_clk_n6);
        count_window(10);

        // Status and IRQ, enables go through register 27
        addr_write(1'b0, fm_regmap_pkg::reg_timer);
        for (int i = 0; i < 24; i++) begin
            r = next_random();
            data_write(1'b0, {4'd0, r[30], r[28], 2'd0});
            flag_a = r[20];
            flag_b = r[24];
            @(negedge clk);
            check_status(status, {1'b1, 5'd0, r[24], r[20]});
            check_bit("irq_n", irq_n, !((r[20] && r[28]) || (r[24] && r[30])));
        end
        wait_busy_low();
        @(negedge clk);
        check_status(status, {1'b0, 5'd0, flag_b, flag_a}); // Busy bit cleared a cycle late

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* all.f */
+incdir+verif
design/fm_regmap_pkg.sv
design/fm_timing_pkg.sv
design/fm_reg_decoder.sv
design/fm_busy_clock.sv
design/fm_status.sv
design/fm_mmr_top.sv
verif/fm_mmr_tb.sv
